// File: src.f
verilog/matmul_pkg.sv
verilog/sync_fifo.sv
verilog/mmio_regs.sv
verilog/matmul_ctrl.sv
verilog/fetch_sched.sv
verilog/block_buffer.sv
verilog/mac_array.sv
verilog/matmul_top.sv
dv/dma_model.sv
dv/matmul_tb.sv

// File: Bender.yml
package:
  name: matmul_accel

sources:
  - files:
      - verilog/matmul_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/mmio_regs.sv
      - verilog/matmul_ctrl.sv
      - verilog/fetch_sched.sv
      - verilog/block_buffer.sv
      - verilog/mac_array.sv
      - verilog/matmul_top.sv
  - target: test
    files:
      - dv/dma_model.sv
      - dv/matmul_tb.sv

// File: dv/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;

    import matmul_pkg::*;

    localparam logic [31:0] SEED = 32'h8860_e454;

    // The queue test runs five commands of 64 blocks
    localparam int TOTAL_BLOCKS   = 2 + 2 + 4 + 5 * 64;
    localparam int BLOCK_CYCLES   = 8;
    localparam int MMIO_CYCLES    = 800;
    localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * BLOCK_CYCLES + MMIO_CYCLES;

    logic        clk;
    logic        reset;
    logic [31:0] mmio_addr;
    logic [31:0] mmio_wdata;
    logic [3:0]  mmio_we;
    logic        mmio_re;
    logic [31:0] mmio_rdata;
    logic [31:0] dma_addr;
    logic        dma_re;
    logic        dma_req_ready;
    logic        dma_resp_valid;
    beat_t       dma_rdata;
    logic        accel_busy;

    int          cycle_count = 0;
    int          exp_res [DIM*DIM];
    logic [31:0] exp_addr_q [$];

    matmul_top matmul_top_inst (
        .clk            (clk),
        .reset          (reset),
        .mmio_addr      (mmio_addr),
        .mmio_wdata     (mmio_wdata),
        .mmio_we        (mmio_we),
        .mmio_re        (mmio_re),
        .mmio_rdata     (mmio_rdata),
        .dma_addr       (dma_addr),
        .dma_re         (dma_re),
        .dma_req_ready  (dma_req_ready),
        .dma_resp_valid (dma_resp_valid),
        .dma_rdata      (dma_rdata),
        .accel_busy     (accel_busy)
    );

    dma_model dma_model_inst (
        .clk            (clk),
        .reset          (reset),
        .dma_re         (dma_re),
        .dma_addr       (dma_addr),
        .dma_req_ready  (dma_req_ready),
        .dma_resp_valid (dma_resp_valid),
        .dma_rdata      (dma_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: accelerator did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "run stopped by timeout");
        end
    end

    // Every DMA request carries the next address of the X walk
    always @(posedge clk) begin
        if (!reset && dma_re) begin
            if (exp_addr_q.size() == 0) begin
                $display("DMA request to %08h when no request was expected", dma_addr);
                $display("Finished with errors");
                $fatal(1, "unexpected DMA request");
            end else begin
                check_value("dma_addr", dma_addr, exp_addr_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------------
    // MMIO access and checking
    // ------------------------------------------------------------------------
    task automatic mmio_write(input logic [7:0] ofs, input logic [31:0] data);
        @(negedge clk);
        mmio_addr  = {24'd0, ofs};
        mmio_wdata = data;
        mmio_we    = 4'hF;
        @(negedge clk);
        mmio_we    = 4'h0;
    endtask

    task automatic mmio_read(input logic [7:0] ofs, output logic [31:0] data);
        @(negedge clk);
        mmio_addr = {24'd0, ofs};
        mmio_re   = 1'b1;
        @(negedge clk);
        mmio_re   = 1'b0;
        data      = mmio_rdata;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t, %s: got %08h, expected %08h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            mmio_read(OFS_CTRL, status);
        end
        check_value("accel_busy", {31'd0, accel_busy}, 32'd0);
        check_value("expected DMA requests left", 32'(exp_addr_q.size()), 32'd0);
    endtask

    task automatic configure(input logic [31:0] x_addr, input logic [31:0] stride,
                             input logic [31:0] m, input logic [31:0] n,
                             input logic [31:0] k, input logic [31:0] row_len);
        mmio_write(OFS_X_ADDR, x_addr);
        mmio_write(OFS_X_STRIDE, stride);
        mmio_write(OFS_M_DIM, m);
        mmio_write(OFS_N_DIM, n);
        mmio_write(OFS_K_DIM, k);
        mmio_write(OFS_K_ROW_LEN, row_len);
    endtask

    task automatic start_cmd();
        mmio_write(OFS_CTRL, 32'd1 << CTRL_START);
        check_value("accel_busy", {31'd0, accel_busy}, 32'd1);
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic signed [7:0] data_byte(logic [31:0] addr, int b);
        return addr[7:0] + 8'(3 * b);
    endfunction

    task automatic reference_model(input logic [31:0] x_addr, input logic [31:0] stride,
                                   input logic [31:0] m, input logic [31:0] n,
                                   input logic [31:0] k, input logic [31:0] row_len);
        logic [31:0]       addr;
        logic [31:0]       row;
        int                nblk;
        int                step;
        logic signed [7:0] a_el;
        logic signed [7:0] b_el;
        for (int c = 0; c < DIM*DIM; c++) begin
            exp_res[c] = 0;
        end
        addr = x_addr;
        row  = 0;
        nblk = int'((k + 32'd3) / 32'd4);
        for (int blk = 0; blk < nblk; blk++) begin
            exp_addr_q.push_back(addr);
            for (int s = 0; s < DIM; s++) begin
                step = blk * DIM + s;
                for (int i = 0; i < DIM; i++) begin
                    for (int j = 0; j < DIM; j++) begin
                        if ((step < k) && (i < m) && (j < n)) begin
                            a_el = data_byte(addr, s * DIM + i);
                            b_el = data_byte(addr, DIM * DIM + s * DIM + j);
                            exp_res[i*DIM + j] += int'(a_el) * int'(b_el);
                        end
                    end
                end
            end
            if ((row_len != 0) && (row + 1 == row_len)) begin
                row  = 0;
                addr = addr + stride;
            end else begin
                row  = row + 1;
                addr = addr + 32;
            end
        end
    endtask

    task automatic verify_results();
        logic [31:0] data;
        for (int c = 0; c < DIM*DIM; c++) begin
            mmio_read(OFS_RESULT + 8'(4 * c), data);
            check_value($sformatf("result[%0d]", c), data, exp_res[c]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic idle_after_reset();
        logic [31:0] data;
        check_value("accel_busy", {31'd0, accel_busy}, 32'd0);
        mmio_read(OFS_CTRL, data);
        check_value("status", data, 32'h0000_000A);
        mmio_read(8'h04, data);
        check_value("unmapped word", data, 32'h0);
        reference_model(32'h0, 32'h0, 0, 0, 0, 0);
        verify_results();
    endtask

    task automatic full_matrix();
        configure(32'h0000_1000, 32'h0, 4, 4, 8, 0);
        reference_model(32'h0000_1000, 32'h0, 4, 4, 8, 0);
        start_cmd();
        wait_done();
        verify_results();
    endtask

    task automatic partial_block();
        configure(32'h0000_2040, 32'h0, 3, 2, 6, 0);
        reference_model(32'h0000_2040, 32'h0, 3, 2, 6, 0);
        start_cmd();
        wait_done();
        verify_results();
    endtask

    task automatic row_stride();
        configure(32'h0000_3010, 32'h0000_0100, 4, 4, 16, 2);
        reference_model(32'h0000_3010, 32'h0000_0100, 4, 4, 16, 2);
        start_cmd();
        wait_done();
        verify_results();
    endtask

    task automatic queue_overflow();
        logic [31:0] status;
        configure(32'h0000_5000, 32'h0, 4, 4, 256, 0);
        // The first start is popped at once and the next four fill the queue
        for (int c = 0; c < 6; c++) begin
            if (c == 5) begin
                mmio_read(OFS_CTRL, status);
                check_value("status", status, 32'h0000_0005);
            end
            mmio_write(OFS_X_ADDR, 32'h0000_5000 + 32'(c) * 32'h11);
            // The model keeps the sums of the last accepted command
            if (c < 5) begin
                reference_model(32'h0000_5000 + 32'(c) * 32'h11, 32'h0, 4, 4, 256, 0);
            end
            start_cmd();
        end
        mmio_read(OFS_CTRL, status);
        check_value("status", status, 32'h0000_0015);
        wait_done();
        mmio_read(OFS_CTRL, status);
        check_value("status", status, 32'h0000_001A);
        verify_results();
        mmio_write(OFS_CTRL, 32'd1 << CTRL_ERR_CLR);
        mmio_read(OFS_CTRL, status);
        check_value("status", status, 32'h0000_000A);
    endtask

    initial begin
        void'($urandom(SEED));
        mmio_addr  = '0;
        mmio_wdata = '0;
        mmio_we    = 4'h0;
        mmio_re    = 1'b0;
        reset      = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        full_matrix();
        partial_block();
        row_stride();
        queue_overflow();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: dv/dma_model.sv
`timescale 1ns/1ps

module dma_model (
    input  logic              clk,
    input  logic              reset,
    input  logic              dma_re,
    input  logic [31:0]       dma_addr,
    output logic              dma_req_ready,
    output logic              dma_resp_valid,
    output matmul_pkg::beat_t dma_rdata
);

    import matmul_pkg::*;

    logic [31:0] addr_q [$];
    int unsigned due_q [$];
    int unsigned cycle = 0;
    logic        ready_q = 1'b0;
    logic        valid_q = 1'b0;
    beat_t       data_q = '0;

    assign dma_req_ready  = ready_q;
    assign dma_resp_valid = valid_q;
    assign dma_rdata      = data_q;

    // Byte b of the beat at address a holds a[7:0] + 3*b
    function automatic beat_t beat_for(logic [31:0] addr);
        logic [255:0] raw;
        for (int b = 0; b < 32; b++) begin
            raw[b*8 +: 8] = addr[7:0] + 8'(3 * b);
        end
        return beat_t'(raw);
    endfunction

    // Requests are taken at the edge where the DUT sees them
    always @(posedge clk) begin
        if (reset) begin
            addr_q.delete();
            due_q.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (dma_re) begin
                addr_q.push_back(dma_addr);
                due_q.push_back(cycle + $urandom_range(5, 1));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Ready stalls and in-order responses
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
            data_q  <= '0;
        end else begin
            // Ready drops about one cycle in four
            ready_q <= ($urandom_range(3) != 0);
            if ((addr_q.size() != 0) && (due_q[0] <= cycle)) begin
                valid_q <= 1'b1;
                data_q  <= beat_for(addr_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                valid_q <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       mmio_addr,
    input  logic [31:0]       mmio_wdata,
    input  logic [3:0]        mmio_we,
    input  logic              mmio_re,
    output logic [31:0]       mmio_rdata,
    output logic [31:0]       dma_addr,
    output logic              dma_re,
    input  logic              dma_req_ready,
    input  logic              dma_resp_valid,
    input  matmul_pkg::beat_t dma_rdata,
    output logic              accel_busy
);

    import matmul_pkg::*;

    logic                 cmd_push;
    logic                 cmd_pop;
    logic                 cmd_full;
    logic                 cmd_empty;
    cmd_t                 cmd_data;
    cmd_t                 cmd_head;
    cmd_t                 active_cmd;
    logic                 start;
    logic                 consume;
    logic                 head_valid;
    beat_t                head;
    logic                 tag_full;
    logic [BUF_DEPTH-1:0] slot_free;
    logic                 issue_valid;
    slot_idx_t            issue_slot;
    result_t              results;

    mmio_regs mmio_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (mmio_wdata),
        .mmio_we    (mmio_we),
        .mmio_re    (mmio_re),
        .mmio_rdata (mmio_rdata),
        .cmd_push   (cmd_push),
        .cmd_data   (cmd_data),
        .cmd_full   (cmd_full),
        .cmd_empty  (cmd_empty),
        .busy       (accel_busy),
        .results    (results)
    );

    sync_fifo #(
        .DEPTH     (CMD_DEPTH),
        .payload_t (cmd_t)
    ) cmd_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .push  (cmd_push),
        .pop   (cmd_pop),
        .din   (cmd_data),
        .dout  (cmd_head),
        .full  (cmd_full),
        .empty (cmd_empty)
    );

    matmul_ctrl matmul_ctrl_inst (
        .clk        (clk),
        .reset      (reset),
        .cmd_empty  (cmd_empty),
        .cmd_head   (cmd_head),
        .cmd_pop    (cmd_pop),
        .start      (start),
        .active_cmd (active_cmd),
        .head_valid (head_valid),
        .consume    (consume),
        .busy       (accel_busy)
    );

    fetch_sched fetch_sched_inst (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .active_cmd    (active_cmd),
        .active        (accel_busy),
        .dma_req_ready (dma_req_ready),
        .tag_full      (tag_full),
        .slot_free     (slot_free),
        .dma_addr      (dma_addr),
        .dma_re        (dma_re),
        .issue_valid   (issue_valid),
        .issue_slot    (issue_slot)
    );

    block_buffer block_buffer_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .issue_valid    (issue_valid),
        .issue_slot     (issue_slot),
        .tag_full       (tag_full),
        .dma_resp_valid (dma_resp_valid),
        .dma_rdata      (dma_rdata),
        .slot_free      (slot_free),
        .head_valid     (head_valid),
        .head           (head),
        .consume        (consume)
    );

    mac_array mac_array_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .active_cmd (active_cmd),
        .consume    (consume),
        .head       (head),
        .results    (results)
    );

endmodule

// File: verilog/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  matmul_pkg::cmd_t    active_cmd,
    input  logic                consume,
    input  matmul_pkg::beat_t   head,
    output matmul_pkg::result_t results
);

    import matmul_pkg::*;

    logic [31:0] k_done;
    logic [31:0] rem;
    word_t       sums [DIM*DIM];

    function automatic logic signed [7:0] elem(block_t blk, int s, int k);
        return $signed(blk[(s*DIM + k)*8 +: 8]);
    endfunction

    // Steps left in this command, the last block may be partial
    assign rem = active_cmd.k_dim - k_done;

    // --------------------------------------------------------------------------
    // Outer product of one block, summed over its live steps
    // --------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sums[i*DIM + j] = '0;
                for (int s = 0; s < DIM; s++) begin
                    if (rem > 32'(s)) begin
                        sums[i*DIM + j] = sums[i*DIM + j]
                                          + elem(head.a, s, i) * elem(head.b, s, j);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            k_done  <= '0;
            results <= '0;
        end else if (consume) begin
            k_done <= k_done + 32'(DIM);
            for (int i = 0; i < DIM; i++) begin
                for (int j = 0; j < DIM; j++) begin
                    // Cells outside M by N keep their zero
                    if ((i < active_cmd.m_dim) && (j < active_cmd.n_dim)) begin
                        results[i*DIM + j] <= results[i*DIM + j] + sums[i*DIM + j];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/block_buffer.sv
`timescale 1ns/1ps

module block_buffer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            issue_valid,
    input  matmul_pkg::slot_idx_t           issue_slot,
    output logic                            tag_full,
    input  logic                            dma_resp_valid,
    input  matmul_pkg::beat_t               dma_rdata,
    output logic [matmul_pkg::BUF_DEPTH-1:0] slot_free,
    output logic                            head_valid,
    output matmul_pkg::beat_t               head,
    input  logic                            consume
);

    import matmul_pkg::*;

    beat_t                mem [BUF_DEPTH];
    logic [BUF_DEPTH-1:0] slot_busy;
    logic [BUF_DEPTH-1:0] slot_full;
    slot_idx_t            use_ptr;
    slot_idx_t            resp_slot;

    // Responses come back in request order, so the tag head names their slot
    sync_fifo #(
        .DEPTH     (TAGQ_DEPTH),
        .payload_t (slot_idx_t)
    ) tag_q (
        .clk   (clk),
        .reset (reset || start),
        .push  (issue_valid),
        .pop   (dma_resp_valid),
        .din   (issue_slot),
        .dout  (resp_slot),
        .full  (tag_full),
        .empty ()
    );

    assign slot_free  = ~slot_busy;
    assign head_valid = slot_full[use_ptr];
    assign head       = mem[use_ptr];

    always_ff @(posedge clk) begin
        if (dma_resp_valid) begin
            mem[resp_slot] <= dma_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            slot_busy <= '0;
            slot_full <= '0;
            use_ptr   <= '0;
        end else begin
            if (issue_valid) begin
                slot_busy[issue_slot] <= 1'b1;
            end
            if (dma_resp_valid) begin
                slot_full[resp_slot] <= 1'b1;
            end
            if (consume) begin
                slot_busy[use_ptr] <= 1'b0;
                slot_full[use_ptr] <= 1'b0;
                use_ptr            <= next_slot(use_ptr);
            end
        end
    end

endmodule

// File: verilog/fetch_sched.sv
`timescale 1ns/1ps

module fetch_sched (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  matmul_pkg::cmd_t                active_cmd,
    input  logic                            active,
    input  logic                            dma_req_ready,
    input  logic                            tag_full,
    input  logic [matmul_pkg::BUF_DEPTH-1:0] slot_free,
    output logic [31:0]                     dma_addr,
    output logic                            dma_re,
    output logic                            issue_valid,
    output matmul_pkg::slot_idx_t           issue_slot
);

    import matmul_pkg::*;

    logic [31:0] x_addr;
    logic [31:0] row_cnt;
    logic [31:0] issued;
    logic [31:0] limit;
    slot_idx_t   fill_slot;
    logic        row_end;

    // Any back-pressure simply holds the request
    assign dma_re = active && !start && (issued != limit) && dma_req_ready
                    && !tag_full && slot_free[fill_slot];

    assign dma_addr    = x_addr;
    assign issue_valid = dma_re;
    assign issue_slot  = fill_slot;

    assign row_end = (active_cmd.k_row_len != '0)
                     && (row_cnt + 32'd1 >= active_cmd.k_row_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            x_addr    <= '0;
            row_cnt   <= '0;
            issued    <= '0;
            limit     <= '0;
            fill_slot <= '0;
        end else if (start) begin
            x_addr    <= active_cmd.x_addr;
            row_cnt   <= '0;
            issued    <= '0;
            limit     <= blocks_for(active_cmd.k_dim);
            fill_slot <= '0;
        end else if (dma_re) begin
            issued    <= issued + 32'd1;
            fill_slot <= next_slot(fill_slot);
            if (row_end) begin
                // Jump to the next row of X
                row_cnt <= '0;
                x_addr  <= x_addr + active_cmd.x_stride;
            end else begin
                row_cnt <= row_cnt + 32'd1;
                x_addr  <= x_addr + 32'(BEAT_BYTES);
            end
        end
    end

endmodule

// File: verilog/matmul_ctrl.sv
`timescale 1ns/1ps

module matmul_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_empty,
    input  matmul_pkg::cmd_t cmd_head,
    output logic             cmd_pop,
    output logic             start,
    output matmul_pkg::cmd_t active_cmd,
    input  logic             head_valid,
    output logic             consume,
    output logic             busy
);

    import matmul_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        DONE
    } state_t;

    state_t      state;
    cmd_t        cmd_q;
    logic [31:0] blk_limit;
    logic [31:0] blk_cnt;

    assign start   = (state == IDLE) && !cmd_empty;
    assign cmd_pop = start;
    assign consume = (state == COMPUTE) && head_valid;
    assign busy    = (state != IDLE) || !cmd_empty;

    // The queue head is the active command during the start cycle
    assign active_cmd = start ? cmd_head : cmd_q;

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q <= cmd_head;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            blk_limit <= '0;
            blk_cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        blk_limit <= blocks_for(cmd_head.k_dim);
                        blk_cnt   <= '0;
                        state     <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (consume) begin
                        blk_cnt <= blk_cnt + 32'd1;
                    end
                    // K of zero finishes without any block
                    if ((blk_limit == '0) || (consume && (blk_cnt + 32'd1 == blk_limit))) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         mmio_addr,
    input  logic [31:0]         mmio_wdata,
    input  logic [3:0]          mmio_we,
    input  logic                mmio_re,
    output logic [31:0]         mmio_rdata,
    output logic                cmd_push,
    output matmul_pkg::cmd_t    cmd_data,
    input  logic                cmd_full,
    input  logic                cmd_empty,
    input  logic                busy,
    input  matmul_pkg::result_t results
);

    import matmul_pkg::*;

    logic       wr;
    logic [7:0] ofs;
    logic       start_wr;
    logic       error;
    logic [7:0] rd_ofs;
    logic [7:0] res_ofs;

    assign wr       = |mmio_we;
    assign ofs      = mmio_addr[7:0];
    assign start_wr = wr && (ofs == OFS_CTRL) && mmio_wdata[CTRL_START];
    assign cmd_push = start_wr && !cmd_full;

    // --------------------------------------------------------------------------
    // Shadow configuration, pushed as a whole on start
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_data <= '0;
        end else if (wr) begin
            case (ofs)
                OFS_X_ADDR:    cmd_data.x_addr    <= mmio_wdata;
                OFS_M_DIM:     cmd_data.m_dim     <= mmio_wdata;
                OFS_N_DIM:     cmd_data.n_dim     <= mmio_wdata;
                OFS_K_DIM:     cmd_data.k_dim     <= mmio_wdata;
                OFS_X_STRIDE:  cmd_data.x_stride  <= mmio_wdata;
                OFS_K_ROW_LEN: cmd_data.k_row_len <= mmio_wdata;
                default: ;
            endcase
        end
    end

    // Sticky error, a rejected start beats err_clr in the same write
    always_ff @(posedge clk) begin
        if (reset) begin
            error <= 1'b0;
        end else if (start_wr && cmd_full) begin
            error <= 1'b1;
        end else if (wr && (ofs == OFS_CTRL) && mmio_wdata[CTRL_ERR_CLR]) begin
            error <= 1'b0;
        end
    end

    // --------------------------------------------------------------------------
    // Read side
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ofs <= '0;
        end else if (mmio_re) begin
            rd_ofs <= ofs;
        end
    end

    // Offsets below OFS_RESULT wrap to a high value here
    assign res_ofs = rd_ofs - OFS_RESULT;

    always_comb begin
        mmio_rdata = '0;
        if (rd_ofs == OFS_CTRL) begin
            mmio_rdata = {27'd0, error, cmd_empty, cmd_full, !busy, busy};
        end else if ((res_ofs[7:6] == 2'b00) && (res_ofs[1:0] == 2'b00)) begin
            mmio_rdata = results[res_ofs[5:2]];
        end
    end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t din,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/matmul_pkg.sv
package matmul_pkg;

    localparam int DIM        = 4;
    localparam int BUF_DEPTH  = 6;
    localparam int TAGQ_DEPTH = 8;
    localparam int CMD_DEPTH  = 4;
    localparam int BEAT_BYTES = 32;

    // Register map, byte offsets
    localparam logic [7:0] OFS_CTRL      = 8'h00;
    localparam logic [7:0] OFS_X_ADDR    = 8'h08;
    localparam logic [7:0] OFS_M_DIM     = 8'h0C;
    localparam logic [7:0] OFS_N_DIM     = 8'h10;
    localparam logic [7:0] OFS_K_DIM     = 8'h14;
    localparam logic [7:0] OFS_RESULT    = 8'h18;
    localparam logic [7:0] OFS_X_STRIDE  = 8'h58;
    localparam logic [7:0] OFS_K_ROW_LEN = 8'h5C;

    localparam int CTRL_START   = 0;
    localparam int CTRL_ERR_CLR = 4;

    typedef logic [2:0] slot_idx_t;

    typedef struct packed {
        logic [31:0] x_addr;
        logic [31:0] x_stride;
        logic [31:0] m_dim;
        logic [31:0] n_dim;
        logic [31:0] k_dim;
        logic [31:0] k_row_len;
    } cmd_t;

    // Byte s*DIM+i is element i of step s
    typedef logic [DIM*DIM*8-1:0] block_t;

    typedef struct packed {
        block_t b;
        block_t a;
    } beat_t;

    typedef logic signed [31:0] word_t;

    // Row-major, word i*DIM+j is c[i][j]
    typedef word_t [DIM*DIM-1:0] result_t;

    // Blocks needed for K steps, ceil(K/4)
    function automatic logic [31:0] blocks_for(logic [31:0] k);
        return 32'(({1'b0, k} + 33'd3) >> 2);
    endfunction

    function automatic slot_idx_t next_slot(slot_idx_t s);
        return (s == slot_idx_t'(BUF_DEPTH - 1)) ? '0 : s + 1'b1;
    endfunction

endpackage
